// ==== audio_pkg.sv ====
////////////////////////////////////////
// sample and gain formats for the audio
// mixing datapath, imported by every
// module that handles audio words
////////////////////////////////////////

`default_nettype none

package audio_pkg;

  localparam int AUDIO_WIDTH = 16;  // signed sample bits
  localparam int GAIN_WIDTH  = 16;  // unsigned gain bits
  localparam int Q_BITS      = 14;  // fractional gain bits

  typedef logic signed [AUDIO_WIDTH-1:0] sample_t;
  typedef logic        [GAIN_WIDTH-1:0]  gain_t;

  // gain integer that scales by exactly one
  localparam gain_t UNITY_GAIN = gain_t'(1 << Q_BITS);

  // saturation limits
  localparam sample_t SAMPLE_MAX = 16'sh7fff;
  localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage

`default_nettype wire

// ==== mix_ctrl_pkg.sv ====
////////////////////////////////////////
// control encodings: channel pan routing
// and I2S transmitter FSM states
////////////////////////////////////////

`default_nettype none

package mix_ctrl_pkg;

  // one routing bit per channel
  typedef enum logic {
    PAN_LEFT  = 1'b0,
    PAN_RIGHT = 1'b1
  } pan_e;

  // transmitter sequencer
  typedef enum logic [1:0] {
    IDLE       = 2'd0,  // waiting for first bit clock fall
    LEFT_SLOT  = 2'd1,  // lrclk low
    RIGHT_SLOT = 2'd2   // lrclk high
  } tx_state_e;

endpackage

`default_nettype wire

// ==== nq_multiplier.sv ====
////////////////////////////////////////
// signed sample times unsigned Q gain,
// floor scaling and saturation, one
// register stage, overflow flags clamping
////////////////////////////////////////

`default_nettype none

module nq_multiplier (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire audio_pkg::sample_t multiplicand,
  input  wire audio_pkg::gain_t   multiplier,
  output audio_pkg::sample_t      product,
  output logic                    overflow
);

  import audio_pkg::*;

  // gain gets a zero sign bit, so the product needs one extra bit
  localparam int PROD_WIDTH = AUDIO_WIDTH + GAIN_WIDTH + 1;

  logic signed [PROD_WIDTH-1:0] full_product;
  logic signed [PROD_WIDTH-1:0] scaled;
  logic                         sat_hi;
  logic                         sat_lo;

  assign full_product = multiplicand * $signed({1'b0, multiplier});
  assign scaled       = full_product >>> Q_BITS;  // rounds toward minus infinity

  assign sat_hi = scaled > SAMPLE_MAX;
  assign sat_lo = scaled < SAMPLE_MIN;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      product  <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= sat_hi | sat_lo;
      if (sat_hi) begin
        product <= SAMPLE_MAX;
      end else if (sat_lo) begin
        product <= SAMPLE_MIN;
      end else begin
        product <= scaled[AUDIO_WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== channel_mixer.sv ====
////////////////////////////////////////
// mono channels to stereo: channel gain,
// hard pan, saturated bus sums and output
// gain, three cycles, sticky clip flags
////////////////////////////////////////

`default_nettype none

module channel_mixer #(
  parameter int NR_CHANNELS = 4
) (
  input  wire                                         clk,
  input  wire                                         rst_n,
  input  wire audio_pkg::sample_t  [NR_CHANNELS-1:0]  channel_data,
  input  wire                                         channel_valid,
  input  wire audio_pkg::gain_t    [NR_CHANNELS-1:0]  channel_gain,
  input  wire mix_ctrl_pkg::pan_e  [NR_CHANNELS-1:0]  channel_pan,
  input  wire audio_pkg::gain_t                       output_gain,
  input  wire                                         status_clear,
  output audio_pkg::sample_t                          mix_left,
  output audio_pkg::sample_t                          mix_right,
  output logic                                        mix_valid,
  output logic                     [NR_CHANNELS-1:0]  channel_clip,
  output logic                                        out_clip
);

  import audio_pkg::*;
  import mix_ctrl_pkg::*;

  // room for NR_CHANNELS full scale products without wrap
  localparam int SUM_WIDTH = AUDIO_WIDTH + $clog2(NR_CHANNELS + 1);

  sample_t                     chan_product [NR_CHANNELS];
  logic    [NR_CHANNELS-1:0]   chan_ovf;
  logic signed [SUM_WIDTH-1:0] left_acc;
  logic signed [SUM_WIDTH-1:0] right_acc;
  sample_t                     bus_left_q;
  logic                        bus_sat;
  sample_t                     bus_right_q;
  logic                        out_ovf_left;
  logic                        out_ovf_right;
  logic [2:0]                  valid_d;    // one bit per stage

  function automatic logic out_of_range(input logic signed [SUM_WIDTH-1:0] value);
    return (value > SAMPLE_MAX) || (value < SAMPLE_MIN);
  endfunction

  function automatic sample_t clamp(input logic signed [SUM_WIDTH-1:0] value);
    if (value > SAMPLE_MAX) return SAMPLE_MAX;
    if (value < SAMPLE_MIN) return SAMPLE_MIN;
    return value[AUDIO_WIDTH-1:0];
  endfunction

  ////////////////////////////////////////
  // stage 1: channel gain
  ////////////////////////////////////////
  for (genvar i = 0; i < NR_CHANNELS; i++) begin : g_chan
    nq_multiplier u_chan_gain (
      .clk          (clk),
      .rst_n        (rst_n),
      .multiplicand (channel_data[i]),
      .multiplier   (channel_gain[i]),
      .product      (chan_product[i]),
      .overflow     (chan_ovf[i])
    );
  end

  ////////////////////////////////////////
  // stage 2: bus sums
  ////////////////////////////////////////
  always_comb begin
    left_acc  = '0;
    right_acc = '0;
    for (int i = 0; i < NR_CHANNELS; i++) begin
      if (channel_pan[i] == PAN_LEFT) begin
        left_acc = left_acc + chan_product[i];
      end else begin
        right_acc = right_acc + chan_product[i];
      end
    end
  end

  assign bus_sat = out_of_range(left_acc) | out_of_range(right_acc);

  always_ff @(posedge clk) begin
    bus_left_q  <= clamp(left_acc);
    bus_right_q <= clamp(right_acc);
  end

  ////////////////////////////////////////
  // stage 3: output gain
  ////////////////////////////////////////
  nq_multiplier u_out_left (
    .clk          (clk),
    .rst_n        (rst_n),
    .multiplicand (bus_left_q),
    .multiplier   (output_gain),
    .product      (mix_left),
    .overflow     (out_ovf_left)
  );

  nq_multiplier u_out_right (
    .clk          (clk),
    .rst_n        (rst_n),
    .multiplicand (bus_right_q),
    .multiplier   (output_gain),
    .product      (mix_right),
    .overflow     (out_ovf_right)
  );

  assign mix_valid = valid_d[2];

  // valid delay line and sticky flags, clear wins only over old state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d      <= '0;
      channel_clip <= '0;
      out_clip     <= 1'b0;
    end else begin
      valid_d      <= {valid_d[1:0], channel_valid};
      channel_clip <= (status_clear ? '0 : channel_clip)
                    | (valid_d[0] ? chan_ovf : '0);
      out_clip     <= (status_clear ? 1'b0 : out_clip)
                    | (valid_d[0] & bus_sat)
                    | (valid_d[2] & (out_ovf_left | out_ovf_right));
    end
  end

endmodule

`default_nettype wire

// ==== sample_fifo.sv ====
////////////////////////////////////////
// stereo sample FIFO between mixer and
// I2S transmitter; full pushes are
// dropped and latched as overrun
////////////////////////////////////////

`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 8  // power of two
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     push,
  input  wire audio_pkg::sample_t wr_left,
  input  wire audio_pkg::sample_t wr_right,
  input  wire                     pop,
  output audio_pkg::sample_t      rd_left,
  output audio_pkg::sample_t      rd_right,
  output logic                    not_empty,
  input  wire                     status_clear,
  output logic                    overrun
);

  import audio_pkg::*;

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  sample_t           mem_left  [FIFO_DEPTH];
  sample_t           mem_right [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   count;
  logic              full;
  logic              do_push;
  logic              do_pop;

  assign full      = count == (ADDR_W + 1)'(FIFO_DEPTH);
  assign not_empty = count != '0;
  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;

  // head word, shows a push one cycle later
  assign rd_left  = mem_left[rd_ptr];
  assign rd_right = mem_right[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_left[wr_ptr]  <= wr_left;
      mem_right[wr_ptr] <= wr_right;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      overrun <= (status_clear ? 1'b0 : overrun) | (push & full);
    end
  end

endmodule

`default_nettype wire

// ==== i2s_tx.sv ====
////////////////////////////////////////
// I2S transmitter, pops one stereo word
// per frame at the lrclk falling edge;
// sends silence and flags underrun if empty
////////////////////////////////////////

`default_nettype none

module i2s_tx #(
  parameter int BCLK_DIV = 2  // clk cycles per bclk half period
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     not_empty,
  input  wire audio_pkg::sample_t rd_left,
  input  wire audio_pkg::sample_t rd_right,
  output logic                    pop,
  input  wire                     status_clear,
  output logic                    i2s_bclk,
  output logic                    i2s_lrclk,
  output logic                    i2s_sdata,
  output logic                    underrun
);

  import audio_pkg::*;
  import mix_ctrl_pkg::*;

  localparam int DIV_W   = $clog2(BCLK_DIV + 1);
  localparam int BIT_W   = $clog2(AUDIO_WIDTH);
  localparam int SHIFT_W = 2 * AUDIO_WIDTH;

  logic [DIV_W-1:0]   div_cnt;
  logic               tick;
  logic               bclk_fall;
  tx_state_e          state;
  logic [BIT_W-1:0]   bit_cnt;    // bclk periods within the slot
  logic               slot_end;
  logic               frame_start;
  logic [SHIFT_W-1:0] shift_q;

  ////////////////////////////////////////
  // bit clock
  ////////////////////////////////////////
  assign tick      = div_cnt == DIV_W'(BCLK_DIV - 1);
  assign bclk_fall = tick && i2s_bclk;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      i2s_bclk <= 1'b0;
    end else if (tick) begin
      div_cnt  <= '0;
      i2s_bclk <= ~i2s_bclk;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////
  assign slot_end    = bit_cnt == BIT_W'(AUDIO_WIDTH - 1);
  assign frame_start = bclk_fall && (state == IDLE || (state == RIGHT_SLOT && slot_end));
  assign pop         = frame_start && not_empty;
  assign i2s_lrclk   = state == RIGHT_SLOT;  // moves only on bclk falls

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else if (bclk_fall) begin
      case (state)
        IDLE: begin
          state   <= LEFT_SLOT;
          bit_cnt <= '0;
        end
        LEFT_SLOT: begin
          if (slot_end) state <= RIGHT_SLOT;
          bit_cnt <= slot_end ? '0 : bit_cnt + 1'b1;
        end
        RIGHT_SLOT: begin
          if (slot_end) state <= LEFT_SLOT;
          bit_cnt <= slot_end ? '0 : bit_cnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // serializer
  ////////////////////////////////////////
  // sdata trails the shift register by one bclk, which gives the
  // I2S one bit delay after each lrclk edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q   <= '0;
      i2s_sdata <= 1'b0;
      underrun  <= 1'b0;
    end else begin
      if (bclk_fall) begin
        i2s_sdata <= shift_q[SHIFT_W-1];
        if (frame_start) begin
          shift_q <= not_empty ? {rd_left, rd_right} : '0;  // silence when empty
        end else begin
          shift_q <= shift_q << 1;
        end
      end
      underrun <= (status_clear ? 1'b0 : underrun) | (frame_start & ~not_empty);
    end
  end

endmodule

`default_nettype wire

// ==== audio_mix_top.sv ====
////////////////////////////////////////
// audio mixing path top: mixer into the
// sample FIFO, drained by the I2S
// transmitter; sets all parameters
////////////////////////////////////////

`default_nettype none

module audio_mix_top #(
  parameter int NR_CHANNELS = 4,
  parameter int FIFO_DEPTH  = 8,
  parameter int BCLK_DIV    = 2
) (
  input  wire                                         clk,
  input  wire                                         rst_n,
  input  wire audio_pkg::sample_t  [NR_CHANNELS-1:0]  channel_data,
  input  wire                                         channel_valid,
  input  wire audio_pkg::gain_t    [NR_CHANNELS-1:0]  channel_gain,
  input  wire mix_ctrl_pkg::pan_e  [NR_CHANNELS-1:0]  channel_pan,
  input  wire audio_pkg::gain_t                       output_gain,
  input  wire                                         status_clear,
  output wire                                         i2s_bclk,
  output wire                                         i2s_lrclk,
  output wire                                         i2s_sdata,
  output wire                      [NR_CHANNELS-1:0]  channel_clip,
  output wire                                         out_clip,
  output wire                                         overrun,
  output wire                                         underrun
);

  import audio_pkg::*;

  sample_t mix_left;
  sample_t mix_right;
  logic    mix_valid;
  sample_t rd_left;
  sample_t rd_right;
  logic    not_empty;
  logic    pop;

  channel_mixer #(
    .NR_CHANNELS (NR_CHANNELS)
  ) u_mixer (
    .clk           (clk),
    .rst_n         (rst_n),
    .channel_data  (channel_data),
    .channel_valid (channel_valid),
    .channel_gain  (channel_gain),
    .channel_pan   (channel_pan),
    .output_gain   (output_gain),
    .status_clear  (status_clear),
    .mix_left      (mix_left),
    .mix_right     (mix_right),
    .mix_valid     (mix_valid),
    .channel_clip  (channel_clip),
    .out_clip      (out_clip)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (mix_valid),   // no back-pressure, drops when full
    .wr_left      (mix_left),
    .wr_right     (mix_right),
    .pop          (pop),
    .rd_left      (rd_left),
    .rd_right     (rd_right),
    .not_empty    (not_empty),
    .status_clear (status_clear),
    .overrun      (overrun)
  );

  i2s_tx #(
    .BCLK_DIV (BCLK_DIV)
  ) u_tx (
    .clk          (clk),
    .rst_n        (rst_n),
    .not_empty    (not_empty),
    .rd_left      (rd_left),
    .rd_right     (rd_right),
    .pop          (pop),
    .status_clear (status_clear),
    .i2s_bclk     (i2s_bclk),
    .i2s_lrclk    (i2s_lrclk),
    .i2s_sdata    (i2s_sdata),
    .underrun     (underrun)
  );

endmodule

`default_nettype wire

// ==== audio_mix_chk.sv ====
////////////////////////////////////////
// concurrent assertions on the FIFO and
// transmitter wires, bound into the top
////////////////////////////////////////

`default_nettype none

module audio_mix_chk #(
  parameter int FIFO_DEPTH = 8
) (
  input wire clk,
  input wire rst_n,
  input wire push,
  input wire pop,
  input wire status_clear,
  input wire overrun,
  input wire i2s_bclk,
  input wire i2s_lrclk
);

  int level;  // words held, followed from the push and pop strobes alone

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= 0;
    end else begin
      level <= level + ((push && level < FIFO_DEPTH) ? 1 : 0) - (pop ? 1 : 0);
    end
  end

  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> level > 0
  ) else $error("pop issued while the FIFO is empty");

  // sticky until cleared
  a_overrun_held: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(overrun) |-> $past(status_clear)
  ) else $error("overrun dropped without status_clear");

  a_lrclk_on_bclk_fall: assert property (
    @(posedge clk) disable iff (!rst_n) $changed(i2s_lrclk) |-> $fell(i2s_bclk)
  ) else $error("lrclk moved away from a bclk falling edge");

endmodule

bind audio_mix_top audio_mix_chk #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .push         (mix_valid),
  .pop          (pop),
  .status_clear (status_clear),
  .overrun      (overrun),
  .i2s_bclk     (i2s_bclk),
  .i2s_lrclk    (i2s_lrclk)
);

`default_nettype wire

// ==== tb_audio_mix.sv ====
////////////////////////////////////////
// directed testbench for the audio mixing
// path; an I2S receiver model collects
// frames, checked against a reference model
////////////////////////////////////////

`default_nettype none

module tb_audio_mix;

  import audio_pkg::*;
  import mix_ctrl_pkg::*;

  localparam int NR_CH          = 4;  // DUT defaults
  localparam int FIFO_DEPTH     = 8;
  localparam int BURST_LEN      = FIFO_DEPTH + 4;
  localparam int TIMEOUT_CYCLES = 20000;  // about 40 test frames of 128 clk, plus margin

  typedef sample_t [NR_CH-1:0] chan_word_t;

  logic                  clk;
  logic                  rst_n;
  chan_word_t            channel_data;
  logic                  channel_valid;
  gain_t     [NR_CH-1:0] channel_gain;
  pan_e      [NR_CH-1:0] channel_pan;
  gain_t                 output_gain;
  logic                  status_clear;
  wire                   i2s_bclk;
  wire                   i2s_lrclk;
  wire                   i2s_sdata;
  wire       [NR_CH-1:0] channel_clip;
  wire                   out_clip;
  wire                   overrun;
  wire                   underrun;

  logic [31:0] rx_shift;
  logic        rx_lr_last;
  sample_t     rx_left_q [$];
  sample_t     rx_right_q [$];
  sample_t     exp_left_q [$];
  sample_t     exp_right_q [$];
  chan_word_t  stim_q [$];
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  integer      seed;

  audio_mix_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .channel_data  (channel_data),
    .channel_valid (channel_valid),
    .channel_gain  (channel_gain),
    .channel_pan   (channel_pan),
    .output_gain   (output_gain),
    .status_clear  (status_clear),
    .i2s_bclk      (i2s_bclk),
    .i2s_lrclk     (i2s_lrclk),
    .i2s_sdata     (i2s_sdata),
    .channel_clip  (channel_clip),
    .out_clip      (out_clip),
    .overrun       (overrun),
    .underrun      (underrun)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clk cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // I2S receiver model
  ////////////////////////////////////////
  // first rising bclk with lrclk low carries the right LSB of the last frame
  always @(posedge i2s_bclk) begin
    rx_shift = {rx_shift[30:0], i2s_sdata};
    if (rx_lr_last && !i2s_lrclk) begin
      rx_left_q.push_back(rx_shift[31:16]);
      rx_right_q.push_back(rx_shift[15:0]);
    end
    rx_lr_last = i2s_lrclk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic sample_t saturate(input longint value);
    if (value > longint'(SAMPLE_MAX)) return SAMPLE_MAX;
    if (value < longint'(SAMPLE_MIN)) return SAMPLE_MIN;
    return sample_t'(value);
  endfunction

  function automatic sample_t apply_gain(input sample_t s, input gain_t g);
    longint full;
    full = longint'(s) * longint'(g);
    return saturate(full >>> Q_BITS);  // floor
  endfunction

  task automatic model_mix(input chan_word_t data, output sample_t l, output sample_t r);
    longint sum_l;
    longint sum_r;
    sum_l = 0;
    sum_r = 0;
    for (int i = 0; i < NR_CH; i++) begin
      if (channel_pan[i] == PAN_LEFT) sum_l += apply_gain(data[i], channel_gain[i]);
      else sum_r += apply_gain(data[i], channel_gain[i]);
    end
    l = apply_gain(saturate(sum_l), output_gain);
    r = apply_gain(saturate(sum_r), output_gain);
  endtask

  function automatic chan_word_t random_word();
    chan_word_t w;
    for (int i = 0; i < NR_CH; i++) w[i] = sample_t'($random(seed));
    return w;
  endfunction

  ////////////////////////////////////////
  // compare and drive helpers
  ////////////////////////////////////////
  task automatic check_sample(input sample_t actual, input sample_t expected, input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      fail_count++;
    end else pass_count++;
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
      fail_count++;
    end else pass_count++;
  endtask

  task automatic wait_frame_start();
    logic lr_prev;
    do begin
      lr_prev = i2s_lrclk;
      @(posedge clk);
      #1;
    end while (!(lr_prev && !i2s_lrclk));
  endtask

  // a few clk past the frame start, so the receiver has stored the frame before
  task automatic wait_frames(input int n);
    repeat (n) wait_frame_start();
    repeat (3) @(posedge clk);
    #1;
  endtask

  task automatic drive_sample(input chan_word_t data);
    channel_data  = data;
    channel_valid = 1'b1;
    @(posedge clk);
    #1;
    channel_valid = 1'b0;
  endtask

  task automatic pulse_clear();
    status_clear = 1'b1;
    @(posedge clk);
    #1;
    status_clear = 1'b0;
  endtask

  task automatic compare_rx(input string name);
    int n;
    if (rx_left_q.size() != exp_left_q.size()) begin
      $display("%s: receiver got %0d frames where %0d were expected",
               name, rx_left_q.size(), exp_left_q.size());
      fail_count++;
    end
    n = (rx_left_q.size() < exp_left_q.size()) ? rx_left_q.size() : exp_left_q.size();
    for (int i = 0; i < n; i++) begin
      check_sample(rx_left_q[i], exp_left_q[i], $sformatf("%s left frame %0d", name, i));
      check_sample(rx_right_q[i], exp_right_q[i], $sformatf("%s right frame %0d", name, i));
    end
  endtask

  // one word per frame; the first received frame is silence
  task automatic play_and_check(input string name);
    sample_t l;
    sample_t r;
    wait_frames(1);
    rx_left_q.delete();
    rx_right_q.delete();
    exp_left_q  = '{16'sd0};
    exp_right_q = '{16'sd0};
    for (int k = 0; k < stim_q.size(); k++) begin
      if (k > 0) wait_frames(1);
      model_mix(stim_q[k], l, r);
      exp_left_q.push_back(l);
      exp_right_q.push_back(r);
      drive_sample(stim_q[k]);
    end
    wait_frames(2);
    compare_rx(name);
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (fail_count == fails_before) $display("test %s: ok", name);
    else $display("test %s: %0d check(s) wrong", name, fail_count - fails_before);
  endtask

  task automatic route(input gain_t g0, input gain_t g1, input gain_t g2, input gain_t g3);
    channel_gain = {g3, g2, g1, g0};
    for (int i = 0; i < NR_CH; i++) channel_pan[i] = (i % 2) ? PAN_RIGHT : PAN_LEFT;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic test_unity_routing();
    int fails_before;
    fails_before = fail_count;
    route(UNITY_GAIN, 16'd0, 16'd0, 16'd0);
    output_gain = UNITY_GAIN;
    stim_q = '{random_word()};
    play_and_check("unity");
    if (rx_left_q.size() > 1) begin
      check_sample(rx_left_q[1], stim_q[0][0], "unity left equals input");
      check_sample(rx_right_q[1], 16'sd0, "unity right is zero");
    end
    report_test("unity routing", fails_before);
  endtask

  task automatic test_mixing();
    int fails_before;
    fails_before = fail_count;
    route(16'h2000, 16'h3000, 16'h1800, 16'h4000);
    output_gain = 16'h5000;  // 1.25
    stim_q.delete();
    repeat (8) stim_q.push_back(random_word());
    play_and_check("mixing");
    report_test("mixing", fails_before);
  endtask

  task automatic test_clipping();
    int fails_before;
    fails_before = fail_count;
    pulse_clear();
    route(16'h8000, 16'd0, 16'd0, 16'd0);  // gain of 2 on channel 0
    output_gain = UNITY_GAIN;
    stim_q = '{{16'sd0, 16'sd0, 16'sd0, 16'sh7fff}};
    play_and_check("channel clip");
    check_flag(channel_clip[0], 1'b1, "channel_clip[0] after full scale x2");
    for (int i = 1; i < NR_CH; i++) begin
      check_flag(channel_clip[i], 1'b0, $sformatf("channel_clip[%0d] untouched", i));
    end
    check_flag(out_clip, 1'b0, "out_clip before bus overflow");
    // both on the left bus
    route(UNITY_GAIN, UNITY_GAIN, 16'd0, 16'd0);
    channel_pan[1] = PAN_LEFT;
    stim_q = '{{16'sd0, 16'sd0, 16'sh7000, 16'sh7000}};
    play_and_check("bus clip");
    check_flag(channel_clip[0], 1'b1, "channel_clip[0] still set");
    check_flag(out_clip, 1'b1, "out_clip after bus overflow");
    pulse_clear();
    check_flag(channel_clip[0], 1'b0, "channel_clip[0] after clear");
    check_flag(out_clip, 1'b0, "out_clip after clear");
    report_test("clipping", fails_before);
  endtask

  task automatic test_overrun();
    int         fails_before;
    chan_word_t w;
    sample_t    l;
    sample_t    r;
    fails_before = fail_count;
    route(UNITY_GAIN, UNITY_GAIN, 16'd0, 16'd0);
    output_gain = UNITY_GAIN;
    wait_frames(1);
    pulse_clear();
    rx_left_q.delete();
    rx_right_q.delete();
    exp_left_q  = '{16'sd0};
    exp_right_q = '{16'sd0};
    for (int k = 0; k < BURST_LEN; k++) begin
      w = '0;
      w[0] = sample_t'(256 * (k + 1));
      w[1] = -w[0];
      model_mix(w, l, r);
      if (k < FIFO_DEPTH) begin  // later words are dropped
        exp_left_q.push_back(l);
        exp_right_q.push_back(r);
      end
      channel_data  = w;
      channel_valid = 1'b1;
      @(posedge clk);
      #1;
    end
    channel_valid = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    check_flag(overrun, 1'b1, "overrun after burst");
    // trailing silence, no dropped word shows up
    exp_left_q.push_back(16'sd0);
    exp_right_q.push_back(16'sd0);
    wait_frames(FIFO_DEPTH + 2);
    compare_rx("overrun");
    report_test("overrun", fails_before);
  endtask

  task automatic test_underrun();
    int fails_before;
    fails_before = fail_count;
    wait_frames(1);
    rx_left_q.delete();
    rx_right_q.delete();
    pulse_clear();
    check_flag(underrun, 1'b0, "underrun after clear");
    exp_left_q  = '{16'sd0, 16'sd0};
    exp_right_q = '{16'sd0, 16'sd0};
    wait_frames(2);
    compare_rx("underrun");
    check_flag(underrun, 1'b1, "underrun with empty FIFO");
    report_test("underrun", fails_before);
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    channel_data  = '0;
    channel_valid = 1'b0;
    channel_gain  = '0;
    channel_pan   = '0;
    output_gain   = '0;
    status_clear  = 1'b0;
    rx_shift      = '0;
    rx_lr_last    = 1'b0;
    pass_count    = 0;
    fail_count    = 0;
    cycle_count   = 0;
    seed          = 32'h4930;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_unity_routing();
    test_mixing();
    test_clipping();
    test_overrun();
    test_underrun();

    $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
audio_pkg.sv
mix_ctrl_pkg.sv
nq_multiplier.sv
channel_mixer.sv
sample_fifo.sv
i2s_tx.sv
audio_mix_top.sv
audio_mix_chk.sv
tb_audio_mix.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_audio_mix
FILELIST = all.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)
FAIL_MSG = TESTBENCH FAILED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
